// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - design

sources:
  - files:
      - design/rv_core_pkg.sv
      - design/rv_fetch.sv
      - design/rv_decode.sv
      - design/rv_reg_file.sv
      - design/rv_execute.sv
      - design/rv_core_top.sv
  - target: test
    files:
      - bench/rv_core_chk.sv
      - bench/rv_core_tb.sv

// ==== bench/rv_core_chk.sv ====
/* rv core port checker
   concurrent assertions on run control and the ecall report, bound into the top level */
module rv_core_chk (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  o_running,
    input  logic  o_done,
    input  logic  o_ecall_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int fail_count = 0;

    // --------------------
    // ecall report
    // --------------------
    a_ecall_pulse : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ecall_valid |=> !o_ecall_valid)
        else begin
            $error("ecall report stayed high for two cycles");
            fail_count++;
        end

    a_ecall_in_done : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_ecall_valid |-> o_done)
        else begin
            $error("ecall reported while the core was not done");
            fail_count++;
        end

    // --------------------
    // run control
    // --------------------
    a_run_excl : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_running && o_done))
        else begin
            $error("running and done were high together");
            fail_count++;
        end

    // done holds until the next reset
    a_done_sticky : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> o_done)
        else begin
            $error("done dropped without a reset");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_chk rv_core_chk_inst (.*);

// ==== bench/rv_core_tb.sv ====
/* rv core testbench
   encodes small programs, runs them on the core and checks the ecall report
   against an in-order register model */
`include "rv_core_defines.svh"

module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS      = 8;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 80;
    localparam int RUN_LIMIT   = 40;
    // funct3 of ADD SUB AND OR XOR SLT SLL SRL
    localparam logic [2:0] F3_TBL [8] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5};

    logic                     i_clk = 1'b0;
    logic                     i_rst_n;
    logic                     i_start;
    logic                     i_imem_we;
    rv_core_pkg::imem_addr_t  i_imem_addr;
    rv_core_pkg::inst_t       i_imem_data;
    logic                     o_running;
    logic                     o_done;
    logic                     o_ecall_valid;
    rv_core_pkg::word_t       o_ecall_data;

    rv_core_pkg::inst_t  prog [$];
    rv_core_pkg::word_t  mreg [32];
    rv_core_pkg::word_t  expect_x10;
    int                  ecall_at;
    logic [31:0]         lfsr = 32'h27715037;
    int                  errors = 0;
    int                  err_mark = 0;
    int                  runs = 0;

    rv_core_top rv_core_top_inst (.*);

    always #(CLK_NS / 2) i_clk = ~i_clk;

    // --------------------
    // random source and encoders
    // --------------------
    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        logic        fb;
        int          b;
        r = '0;
        for (b = 0; b < nbits; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic rv_core_pkg::inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
        input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::reg_idx_t rs1,
        input rv_core_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
    endfunction

    function automatic rv_core_pkg::inst_t enc_i(input logic [2:0] f3,
        input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::reg_idx_t rs1,
        input logic [11:0] imm);
        return {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
    endfunction

    // reference alu, straight from the isa rules
    function automatic rv_core_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
        input rv_core_pkg::word_t a, input rv_core_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return a >> b[4:0];
            3'd6:    return a | b;
            3'd7:    return a & b;
            default: return '0;
        endcase
    endfunction

    // --------------------
    // program builder with model
    // --------------------
    task automatic begin_prog();
        prog.delete();
        foreach (mreg[r]) mreg[r] = '0;
    endtask

    task automatic model_write(input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::word_t v);
        if (rd != 5'd0) mreg[rd] = v;
    endtask

    task automatic op_r(input logic [6:0] f7, input logic [2:0] f3,
        input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::reg_idx_t rs1,
        input rv_core_pkg::reg_idx_t rs2);
        prog.push_back(enc_r(f7, f3, rd, rs1, rs2));
        model_write(rd, alu_model(f3, f7[5], mreg[rs1], mreg[rs2]));
    endtask

    task automatic op_i(input logic [2:0] f3, input rv_core_pkg::reg_idx_t rd,
        input rv_core_pkg::reg_idx_t rs1, input logic [11:0] imm);
        prog.push_back(enc_i(f3, rd, rs1, imm));
        model_write(rd, alu_model(f3, 1'b0, mreg[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic op_lui(input rv_core_pkg::reg_idx_t rd, input logic [19:0] imm);
        prog.push_back({imm, rd, `RV_OPC_LUI});
        model_write(rd, {imm, 12'h000});
    endtask

    // unknown encodings and words behind the ecall leave the model alone
    task automatic op_raw(input rv_core_pkg::inst_t w);
        prog.push_back(w);
    endtask

    task automatic finish_prog();
        ecall_at   = prog.size();
        expect_x10 = mreg[10];
        prog.push_back({25'd0, `RV_OPC_SYSTEM});
    endtask

    task automatic add_fillers(input int n);
        int j;
        for (j = 0; j < n; j++) begin
            op_i(3'd0, 5'(20 + rand_bits(3)), 5'd0, 12'(rand_bits(12)));
        end
    endtask

    // --------------------
    // drivers
    // --------------------
    task automatic apply_reset();
        i_rst_n = 1'b0;
        repeat (2) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
    endtask

    task automatic load_prog();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            i_imem_we   = 1'b1;
            i_imem_addr = rv_core_pkg::imem_addr_t'(i);
            i_imem_data = prog[i];
            @(posedge i_clk);
            #1;
        end
        i_imem_we = 1'b0;
    endtask

    // reset, load, start, then wait for the ecall report
    task automatic run_prog(input int post, input bit scribble);
        int n;
        bit seen;
        runs++;
        apply_reset();
        load_prog();
        i_start = 1'b1;
        @(posedge i_clk);
        #1 i_start = 1'b0;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < RUN_LIMIT) begin
            // overwrite the words still ahead of the pc
            if (scribble) begin
                i_imem_we   = 1'b1;
                i_imem_addr = rv_core_pkg::imem_addr_t'(n + 1);
                i_imem_data = enc_i(3'd0, 5'd10, 5'd0, 12'h7ff);
            end
            @(posedge i_clk);
            #1;
            n++;
            seen = o_ecall_valid;
        end
        i_imem_we = 1'b0;
        assert (seen) else begin
            $error("no ecall report within %0d cycles of start", RUN_LIMIT);
            errors++;
        end
        if (seen) begin
            assert (n == ecall_at + 3) else begin
                $error("ERROR o_ecall_valid edge 0x%0h expected 0x%0h", n, ecall_at + 3);
                errors++;
            end
            assert (o_ecall_data === expect_x10) else begin
                $error("ERROR o_ecall_data 0x%08h expected 0x%08h", o_ecall_data, expect_x10);
                errors++;
            end
        end
        repeat (post) begin
            @(posedge i_clk);
            #1;
            assert (!o_ecall_valid && o_done && !o_running) else begin
                $error("core left the halted state after the ecall report");
                errors++;
            end
            assert (o_ecall_data === '0) else begin
                $error("ERROR o_ecall_data 0x%08h expected 0x%08h", o_ecall_data, 32'h0);
                errors++;
            end
        end
    endtask

    task automatic test_done(input string name);
        $display("test %-10s : %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // --------------------
    // tests
    // --------------------
    initial begin
        int          i;
        int          d;
        int          fails;
        logic [2:0]  f3;
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;

        apply_reset();
        repeat (10) begin
            @(posedge i_clk);
            #1;
            assert ({o_running, o_done, o_ecall_valid} == 3'b000) else begin
                $error("ERROR running/done/ecall_valid 0x%0h expected 0x0",
                       {o_running, o_done, o_ecall_valid});
                errors++;
            end
        end
        test_done("idle");

        for (i = 0; i < 16; i++) begin
            begin_prog();
            op_i(3'd0, 5'd1, 5'd0, 12'(rand_bits(12)));
            op_i(3'd0, 5'd2, 5'd0, 12'(rand_bits(12)));
            if (i < 8) begin
                op_r((i == 1) ? 7'h20 : 7'h00, F3_TBL[i], 5'd3, 5'd1, 5'd2);
            end else if (i < 15) begin
                f3 = F3_TBL[i - 7];
                if (f3 == 3'd1 || f3 == 3'd5) op_i(f3, 5'd3, 5'd1, 12'(rand_bits(5)));
                else op_i(f3, 5'd3, 5'd1, 12'(rand_bits(12)));
            end else begin
                op_lui(5'd3, 20'(rand_bits(20)));
            end
            op_i(3'd0, 5'd10, 5'd3, 12'h000);
            finish_prog();
            run_prog(1, 1'b0);
        end
        test_done("alu");

        // producer to consumer distance d+1
        for (d = 0; d < 4; d++) begin
            begin_prog();
            op_i(3'd0, 5'd1, 5'd0, 12'(rand_bits(12)));
            add_fillers(d);
            op_r(7'h00, 3'd0, 5'd2, 5'd1, 5'd1);
            add_fillers(d);
            op_r(7'h20, 3'd0, 5'd3, 5'd2, 5'd1);
            add_fillers(d);
            op_r(7'h00, 3'd0, 5'd10, 5'd3, 5'd2);
            finish_prog();
            run_prog(1, 1'b0);
        end
        test_done("forwarding");

        begin_prog();
        op_i(3'd0, 5'd10, 5'd0, 12'(rand_bits(12)));
        op_i(3'd0, 5'd0, 5'd0, 12'(rand_bits(12)));
        op_lui(5'd0, 20'(rand_bits(20)));
        op_r(7'h00, 3'd0, 5'd10, 5'd10, 5'd0);
        // mul, lw and sra are not part of the kept set
        op_raw(enc_r(7'h01, 3'd0, 5'd10, 5'd10, 5'd10));
        op_raw({12'h000, 5'd0, 3'b010, 5'd10, 7'b0000011});
        op_raw(enc_r(7'h20, 3'd5, 5'd10, 5'd10, 5'd10));
        finish_prog();
        run_prog(1, 1'b0);
        test_done("x0");

        begin_prog();
        op_i(3'd0, 5'd10, 5'd0, 12'(rand_bits(12)));
        op_i(3'd0, 5'd11, 5'd0, 12'(rand_bits(12)));
        op_r(7'h00, 3'd0, 5'd10, 5'd10, 5'd11);
        op_i(3'd4, 5'd10, 5'd10, 12'(rand_bits(12)));
        finish_prog();
        repeat (3) op_raw(enc_i(3'd0, 5'd10, 5'd10, 12'h001));
        // would report a second time if fetch ran past the first ecall
        op_raw({25'd0, `RV_OPC_SYSTEM});
        run_prog(12, 1'b0);
        test_done("halt");

        begin_prog();
        op_i(3'd0, 5'd5, 5'd0, 12'(rand_bits(12)));
        op_lui(5'd6, 20'(rand_bits(20)));
        op_r(7'h00, 3'd6, 5'd10, 5'd5, 5'd6);
        op_i(3'd0, 5'd10, 5'd10, 12'(rand_bits(12)));
        finish_prog();
        run_prog(1, 1'b1);
        test_done("load port");

        fails = rv_core_top_inst.rv_core_chk_inst.fail_count;
        $display("runs %0d, check errors %0d, assertion failures %0d", runs, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog sized from the test count
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_NS);
        $display("watchdog expired after %0d ns", NUM_TESTS * TEST_CYCLES * CLK_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== design/rv_core_defines.svh ====
/* rv core constants
   data and index widths, memory depth, opcodes and the ecall report register */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// widths and depths
`define RV_XLEN        32
`define RV_REG_AW      5
`define RV_IMEM_DEPTH  64
`define RV_IMEM_AW     6

// major opcodes, inst[6:0]
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_SYSTEM  7'b1110011

// register shown on the ecall outputs
`define RV_ECALL_REG   5'd10

`endif

// ==== design/rv_core_pkg.sv ====
/* rv core types
   vector typedefs for the meaningful widths and enums for the alu and run control */
`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0]    word_t;
    typedef logic [31:0]            inst_t;
    typedef logic [`RV_REG_AW-1:0]  reg_idx_t;
    // also the width of the program counter
    typedef logic [`RV_IMEM_AW-1:0] imem_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_DONE
    } run_state_e;

endpackage

// ==== design/rv_core_top.sv ====
/* rv core top
   in-order rv32i subset pipeline: fetch, decode, register file and execute */
module rv_core_top (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  logic                     i_imem_we,
    input  rv_core_pkg::imem_addr_t  i_imem_addr,
    input  rv_core_pkg::inst_t       i_imem_data,
    output logic                     o_running,
    output logic                     o_done,
    output logic                     o_ecall_valid,
    output rv_core_pkg::word_t       o_ecall_data
);

    // fetch to decode
    rv_core_pkg::inst_t      inst;
    logic                    inst_valid;
    logic                    is_ecall;

    // decode to register file
    rv_core_pkg::reg_idx_t   rd_rs1, rd_rs2;

    // register-read stage
    rv_core_pkg::reg_idx_t   ex_rd, ex_rs1, ex_rs2;
    rv_core_pkg::word_t      ex_imm;
    logic                    ex_use_imm;
    rv_core_pkg::alu_op_e    ex_alu_op;
    logic                    ex_reg_write;
    logic                    ex_ecall;
    rv_core_pkg::word_t      rs1_data, rs2_data;

    // write back
    logic                    wb_en;
    rv_core_pkg::reg_idx_t   wb_rd;
    rv_core_pkg::word_t      wb_data;

    rv_fetch rv_fetch_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
        .i_is_ecall(is_ecall),
        .o_inst(inst), .o_inst_valid(inst_valid),
        .o_running(o_running), .o_done(o_done)
    );

    rv_decode rv_decode_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_inst(inst), .i_inst_valid(inst_valid),
        .o_is_ecall(is_ecall), .o_rd_rs1(rd_rs1), .o_rd_rs2(rd_rs2),
        .o_ex_rd(ex_rd), .o_ex_rs1(ex_rs1), .o_ex_rs2(ex_rs2), .o_ex_imm(ex_imm),
        .o_ex_use_imm(ex_use_imm), .o_ex_alu_op(ex_alu_op),
        .o_ex_reg_write(ex_reg_write), .o_ex_ecall(ex_ecall)
    );

    rv_reg_file rv_reg_file_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_rs1_addr(rd_rs1), .i_rs2_addr(rd_rs2),
        .i_wr_en(wb_en), .i_wr_addr(wb_rd), .i_wr_data(wb_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    rv_execute rv_execute_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_rd(ex_rd), .i_rs1(ex_rs1), .i_rs2(ex_rs2), .i_imm(ex_imm),
        .i_use_imm(ex_use_imm), .i_alu_op(ex_alu_op), .i_reg_write(ex_reg_write),
        .i_ecall(ex_ecall), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_wb_en(wb_en), .o_wb_rd(wb_rd), .o_wb_data(wb_data),
        .o_ecall_valid(o_ecall_valid), .o_ecall_data(o_ecall_data)
    );

endmodule

// ==== design/rv_decode.sv ====
/* rv decode
   instruction decoder feeding the decode and register-read pipeline registers */
`include "rv_core_defines.svh"

module rv_decode (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  rv_core_pkg::inst_t     i_inst,
    input  logic                   i_inst_valid,
    output logic                   o_is_ecall,
    output rv_core_pkg::reg_idx_t  o_rd_rs1,
    output rv_core_pkg::reg_idx_t  o_rd_rs2,
    output rv_core_pkg::reg_idx_t  o_ex_rd,
    output rv_core_pkg::reg_idx_t  o_ex_rs1,
    output rv_core_pkg::reg_idx_t  o_ex_rs2,
    output rv_core_pkg::word_t     o_ex_imm,
    output logic                   o_ex_use_imm,
    output rv_core_pkg::alu_op_e   o_ex_alu_op,
    output logic                   o_ex_reg_write,
    output logic                   o_ex_ecall
);

    logic [6:0]             opcode, funct7;
    logic [2:0]             funct3;
    rv_core_pkg::reg_idx_t  dec_rd, dec_rs1, dec_rs2;
    rv_core_pkg::word_t     dec_imm;
    rv_core_pkg::alu_op_e   dec_alu_op;
    logic                   dec_use_imm, dec_known, dec_ecall, dec_reg_write;

    // decode register
    rv_core_pkg::reg_idx_t  d_rd, d_rs1, d_rs2;
    rv_core_pkg::word_t     d_imm;
    rv_core_pkg::alu_op_e   d_alu_op;
    logic                   d_use_imm, d_reg_write, d_ecall;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    // --------------------
    // field decode
    // --------------------
    always_comb begin
        dec_rd      = i_inst[11:7];
        dec_rs1     = i_inst[19:15];
        dec_rs2     = i_inst[24:20];
        dec_imm     = {{20{i_inst[31]}}, i_inst[31:20]};
        dec_alu_op  = rv_core_pkg::ALU_ADD;
        dec_use_imm = 1'b0;
        dec_known   = 1'b0;
        dec_ecall   = 1'b0;
        case (opcode)
            `RV_OPC_OP: begin
                // only SUB may set funct7[5]
                dec_known = (funct7 == 7'b0000000) ||
                            (funct3 == 3'b000 && funct7 == 7'b0100000);
                case (funct3)
                    3'b000:  dec_alu_op = funct7[5] ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                    3'b001:  dec_alu_op = rv_core_pkg::ALU_SLL;
                    3'b010:  dec_alu_op = rv_core_pkg::ALU_SLT;
                    3'b100:  dec_alu_op = rv_core_pkg::ALU_XOR;
                    3'b101:  dec_alu_op = rv_core_pkg::ALU_SRL;
                    3'b110:  dec_alu_op = rv_core_pkg::ALU_OR;
                    3'b111:  dec_alu_op = rv_core_pkg::ALU_AND;
                    default: dec_known  = 1'b0;
                endcase
            end
            `RV_OPC_OP_IMM: begin
                dec_use_imm = 1'b1;
                dec_known   = 1'b1;
                case (funct3)
                    3'b000:  dec_alu_op = rv_core_pkg::ALU_ADD;
                    3'b010:  dec_alu_op = rv_core_pkg::ALU_SLT;
                    3'b100:  dec_alu_op = rv_core_pkg::ALU_XOR;
                    3'b110:  dec_alu_op = rv_core_pkg::ALU_OR;
                    3'b111:  dec_alu_op = rv_core_pkg::ALU_AND;
                    3'b001: begin
                        dec_alu_op = rv_core_pkg::ALU_SLL;
                        dec_known  = (funct7 == 7'b0000000);
                    end
                    3'b101: begin
                        // SRAI is not kept
                        dec_alu_op = rv_core_pkg::ALU_SRL;
                        dec_known  = (funct7 == 7'b0000000);
                    end
                    default: dec_known = 1'b0;
                endcase
            end
            `RV_OPC_LUI: begin
                // x0 + upper immediate
                dec_rs1     = '0;
                dec_imm     = {i_inst[31:12], 12'b0};
                dec_use_imm = 1'b1;
                dec_known   = 1'b1;
            end
            `RV_OPC_SYSTEM: begin
                if (i_inst[31:7] == '0) begin
                    dec_ecall = 1'b1;
                    dec_rs1   = `RV_ECALL_REG;
                end
            end
            default: dec_known = 1'b0;
        endcase
    end

    assign dec_reg_write = dec_known && (dec_rd != '0);
    assign o_is_ecall    = dec_ecall;

    // --------------------
    // pipeline registers
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            {d_rd, d_rs1, d_rs2, d_imm} <= '0;
            {o_ex_rd, o_ex_rs1, o_ex_rs2, o_ex_imm} <= '0;
            d_alu_op       <= rv_core_pkg::ALU_ADD;
            o_ex_alu_op    <= rv_core_pkg::ALU_ADD;
            {d_use_imm, d_reg_write, d_ecall} <= '0;
            {o_ex_use_imm, o_ex_reg_write, o_ex_ecall} <= '0;
        end else begin
            // bubble when fetch has nothing valid
            d_rd           <= dec_rd;
            d_rs1          <= dec_rs1;
            d_rs2          <= dec_rs2;
            d_imm          <= dec_imm;
            d_alu_op       <= dec_alu_op;
            d_use_imm      <= dec_use_imm;
            d_reg_write    <= i_inst_valid && dec_reg_write;
            d_ecall        <= i_inst_valid && dec_ecall;
            o_ex_rd        <= d_rd;
            o_ex_rs1       <= d_rs1;
            o_ex_rs2       <= d_rs2;
            o_ex_imm       <= d_imm;
            o_ex_alu_op    <= d_alu_op;
            o_ex_use_imm   <= d_use_imm;
            o_ex_reg_write <= d_reg_write;
            o_ex_ecall     <= d_ecall;
        end
    end

    assign o_rd_rs1 = d_rs1;
    assign o_rd_rs2 = d_rs2;

endmodule

// ==== design/rv_execute.sv ====
/* rv execute
   operand forwarding, alu, ecall report and the alu-result and write-back registers */
module rv_execute (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  rv_core_pkg::reg_idx_t  i_rd,
    input  rv_core_pkg::reg_idx_t  i_rs1,
    input  rv_core_pkg::reg_idx_t  i_rs2,
    input  rv_core_pkg::word_t     i_imm,
    input  logic                   i_use_imm,
    input  rv_core_pkg::alu_op_e   i_alu_op,
    input  logic                   i_reg_write,
    input  logic                   i_ecall,
    input  rv_core_pkg::word_t     i_rs1_data,
    input  rv_core_pkg::word_t     i_rs2_data,
    output logic                   o_wb_en,
    output rv_core_pkg::reg_idx_t  o_wb_rd,
    output rv_core_pkg::word_t     o_wb_data,
    output logic                   o_ecall_valid,
    output rv_core_pkg::word_t     o_ecall_data
);

    rv_core_pkg::word_t     op_a, op_b, alu_out;
    // alu-result register
    logic                   alu_we_q;
    rv_core_pkg::reg_idx_t  alu_rd_q;
    rv_core_pkg::word_t     alu_result_q;

    // newest producer wins: alu-result, then write-back, then register file
    function automatic rv_core_pkg::word_t fwd_operand(
        input rv_core_pkg::reg_idx_t src,
        input rv_core_pkg::word_t    rf_data
    );
        if (alu_we_q && alu_rd_q == src) return alu_result_q;
        if (o_wb_en && o_wb_rd == src) return o_wb_data;
        return rf_data;
    endfunction

    // --------------------
    // operands and alu
    // --------------------
    always_comb begin
        op_a = fwd_operand(i_rs1, i_rs1_data);
        op_b = i_use_imm ? i_imm : fwd_operand(i_rs2, i_rs2_data);
    end

    always_comb begin
        case (i_alu_op)
            rv_core_pkg::ALU_ADD: alu_out = op_a + op_b;
            rv_core_pkg::ALU_SUB: alu_out = op_a - op_b;
            rv_core_pkg::ALU_AND: alu_out = op_a & op_b;
            rv_core_pkg::ALU_OR:  alu_out = op_a | op_b;
            rv_core_pkg::ALU_XOR: alu_out = op_a ^ op_b;
            rv_core_pkg::ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLL: alu_out = op_a << op_b[4:0];
            rv_core_pkg::ALU_SRL: alu_out = op_a >> op_b[4:0];
            default:              alu_out = '0;
        endcase
    end

    // --------------------
    // result registers
    // --------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            alu_we_q      <= 1'b0;
            alu_rd_q      <= '0;
            o_wb_en       <= 1'b0;
            o_wb_rd       <= '0;
            o_ecall_valid <= 1'b0;
            o_ecall_data  <= '0;
        end else begin
            alu_we_q      <= i_reg_write;
            alu_rd_q      <= i_rd;
            o_wb_en       <= alu_we_q;
            o_wb_rd       <= alu_rd_q;
            // x10 arrives on operand a
            o_ecall_valid <= i_ecall;
            o_ecall_data  <= i_ecall ? op_a : '0;
        end
    end

    always_ff @(posedge i_clk) begin
        alu_result_q <= alu_out;
        o_wb_data    <= alu_result_q;
    end

endmodule

// ==== design/rv_fetch.sv ====
/* rv fetch
   run-control fsm, program counter and instruction memory with a load port */
`include "rv_core_defines.svh"

module rv_fetch (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start,
    input  logic                     i_imem_we,
    input  rv_core_pkg::imem_addr_t  i_imem_addr,
    input  rv_core_pkg::inst_t       i_imem_data,
    input  logic                     i_is_ecall,
    output rv_core_pkg::inst_t       o_inst,
    output logic                     o_inst_valid,
    output logic                     o_running,
    output logic                     o_done
);

    rv_core_pkg::run_state_e  state, next_state;
    rv_core_pkg::imem_addr_t  pc;
    rv_core_pkg::inst_t       imem [`RV_IMEM_DEPTH];

    // --------------------
    // run control
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            rv_core_pkg::ST_IDLE: begin
                if (i_start) next_state = rv_core_pkg::ST_EXEC;
            end
            rv_core_pkg::ST_EXEC: begin
                if (i_is_ecall) next_state = rv_core_pkg::ST_DONE;
            end
            // stays done until reset
            rv_core_pkg::ST_DONE: next_state = rv_core_pkg::ST_DONE;
            default: next_state = rv_core_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= rv_core_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // --------------------
    // program counter
    // --------------------
    // frozen on an ecall so the pipeline drains behind it
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= '0;
        end else if (state == rv_core_pkg::ST_EXEC && !i_is_ecall) begin
            pc <= pc + 1'b1;
        end
    end

    // --------------------
    // instruction memory
    // --------------------
    // load port only takes effect while idle
    always_ff @(posedge i_clk) begin
        if (i_imem_we && state == rv_core_pkg::ST_IDLE) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    assign o_inst       = imem[pc];
    assign o_running    = (state == rv_core_pkg::ST_EXEC);
    assign o_done       = (state == rv_core_pkg::ST_DONE);
    assign o_inst_valid = o_running;

endmodule

// ==== design/rv_reg_file.sv ====
/* rv register file
   32 words with registered reads, write-through and x0 tied to zero */
`include "rv_core_defines.svh"

module rv_reg_file (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  rv_core_pkg::reg_idx_t  i_rs1_addr,
    input  rv_core_pkg::reg_idx_t  i_rs2_addr,
    input  logic                   i_wr_en,
    input  rv_core_pkg::reg_idx_t  i_wr_addr,
    input  rv_core_pkg::word_t     i_wr_data,
    output rv_core_pkg::word_t     o_rs1_data,
    output rv_core_pkg::word_t     o_rs2_data
);

    rv_core_pkg::word_t  regs [2**`RV_REG_AW];
    logic                wr_ok;

    assign wr_ok = i_wr_en && (i_wr_addr != '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**`RV_REG_AW; i++) begin
                regs[i] <= '0;
            end
            o_rs1_data <= '0;
            o_rs2_data <= '0;
        end else begin
            if (wr_ok) regs[i_wr_addr] <= i_wr_data;
            // same-cycle write shows up in the read
            o_rs1_data <= (wr_ok && i_wr_addr == i_rs1_addr) ? i_wr_data : regs[i_rs1_addr];
            o_rs2_data <= (wr_ok && i_wr_addr == i_rs2_addr) ? i_wr_data : regs[i_rs2_addr];
        end
    end

endmodule

// ==== rv_core.f ====
+incdir+design
design/rv_core_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_reg_file.sv
design/rv_execute.sv
design/rv_core_top.sv
bench/rv_core_chk.sv
bench/rv_core_tb.sv
